// File: src/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// CPU ports sharing the bus
`define BUS_N_MASTERS   4

`define BUS_ADDR_W      4
`define BUS_DATA_W      16
`define BUS_MEM_DEPTH   16

// Cycles the owner spends in WAIT for every transfer
`define BUS_WAIT_STATES 2

`endif

// File: src/mem_pkg.sv
`include "bus_config.svh"

package mem_pkg;

    // ====================
    // Memory side types
    // ====================

    typedef logic [`BUS_DATA_W-1:0] mem_word_t;

    typedef logic [`BUS_ADDR_W-1:0] mem_addr_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage

// File: src/bus_pkg.sv
package bus_pkg;

    import mem_pkg::*;

    // ====================
    // Bus side types
    // ====================

    // Same six phases as the original CPU bus sequencer
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        REQ    = 3'd1,
        ADDR   = 3'd2,
        WAIT   = 3'd3,
        DATA   = 3'd4,
        FINISH = 3'd5
    } master_state_t;

    // One single-beat transfer as it travels across the bus
    typedef struct packed {
        mem_op_t   op;
        mem_addr_t addr;
        mem_word_t wdata;
    } bus_xfer_t;

endpackage

// File: src/master_link_if.sv
`timescale 1ns/1ps

interface master_link_if
    import mem_pkg::*;
    import bus_pkg::*;
();

    logic      req;
    logic      ack;
    logic      addr_phase;
    bus_xfer_t xfer;
    logic      wait_s;
    logic      data_phase;
    mem_word_t rdata;

    modport master (
        output req,
        output addr_phase,
        output xfer,
        output data_phase,
        input  ack,
        input  wait_s,
        input  rdata
    );

    modport fabric (
        input  req,
        input  addr_phase,
        input  xfer,
        input  data_phase,
        output ack,
        output wait_s,
        output rdata
    );

endinterface

// File: src/cpu_bus_master.sv
`timescale 1ns/1ps

module cpu_bus_master
    import mem_pkg::*;
    import bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 memop,
    input  mem_op_t              op,
    input  mem_addr_t            addr,
    input  mem_word_t            wdata,
    output logic                 stall,
    output logic                 done,
    output mem_word_t            rdata,
    master_link_if.master        link
);

    master_state_t state;
    master_state_t state_nxt;
    bus_xfer_t     xfer_q;
    mem_word_t     rdata_q;
    logic          rd_done;

    // ====================
    // Sequencer
    // ====================

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (memop) state_nxt = REQ;
            REQ:     if (link.ack) state_nxt = ADDR;
            ADDR:    state_nxt = WAIT;
            WAIT:    if (!link.wait_s) state_nxt = DATA;
            DATA:    state_nxt = FINISH;
            // One spare cycle so the arbiter sees req fall before a new request
            FINISH:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Operands are frozen for the whole transfer once the sequencer leaves IDLE
    always_ff @(posedge clk) begin
        if (state == IDLE && memop) begin
            xfer_q <= '{op: op, addr: addr, wdata: wdata};
        end
    end

    // ====================
    // CPU side
    // ====================

    // The stall has to beat the clock edge, so a memop seen in IDLE stalls at once
    assign stall = (state == IDLE) ? memop : (state != FINISH);
    assign done  = (state == DATA);

    assign rd_done = done && (xfer_q.op == MEM_READ);

    always_ff @(posedge clk) begin
        if (rd_done) begin
            rdata_q <= link.rdata;
        end
    end

    // Read word is passed straight through in DATA and held afterwards
    assign rdata = rd_done ? link.rdata : rdata_q;

    // ====================
    // Bus side
    // ====================

    // Request follows the stall so that a free bus grants while we sit in REQ
    assign link.req        = stall;
    assign link.addr_phase = (state == ADDR);
    assign link.data_phase = (state == DATA);
    assign link.xfer       = xfer_q;

    ack_only_in_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        link.ack |-> state == REQ
    ) else $error("bus ack seen outside REQ, state %s", state.name());

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

`include "bus_config.svh"

module bus_arbiter
    import mem_pkg::*;
    import bus_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    master_link_if.fabric links [`BUS_N_MASTERS],
    output logic          addr_phase,
    output bus_xfer_t     xfer,
    input  logic          wait_s,
    input  mem_word_t     rdata
);

    localparam int N     = `BUS_N_MASTERS;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]     req_v;
    logic [N-1:0]     addr_phase_v;
    logic [N-1:0]     data_phase_v;
    bus_xfer_t        xfer_v [N];
    logic [N-1:0]     ack_q;
    logic             busy;
    logic [IDX_W-1:0] owner;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] cand;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_any;

    for (genvar i = 0; i < N; i++) begin : g_link
        assign req_v[i]        = links[i].req;
        assign addr_phase_v[i] = links[i].addr_phase;
        assign data_phase_v[i] = links[i].data_phase;
        assign xfer_v[i]       = links[i].xfer;

        assign links[i].ack    = ack_q[i];
        // Anyone but the owner is told to keep waiting
        assign links[i].wait_s = (busy && owner == IDX_W'(i)) ? wait_s : 1'b1;
        assign links[i].rdata  = (busy && owner == IDX_W'(i) && data_phase_v[i]) ? rdata : '0;
    end

    // ====================
    // Round robin pick
    // ====================

    // Search starts one past the previous owner
    always_comb begin
        grant_any = 1'b0;
        grant_idx = rr_ptr;
        for (int k = 0; k < N; k++) begin
            cand = IDX_W'((int'(rr_ptr) + k) % N);
            if (!grant_any && req_v[cand]) begin
                grant_any = 1'b1;
                grant_idx = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            owner  <= '0;
            rr_ptr <= '0;
            ack_q  <= '0;
        end else begin
            ack_q <= '0;
            if (!busy && grant_any) begin
                busy             <= 1'b1;
                owner            <= grant_idx;
                rr_ptr           <= (grant_idx == IDX_W'(N - 1)) ? '0 : grant_idx + 1'b1;
                ack_q[grant_idx] <= 1'b1;
            end else if (busy && !req_v[owner]) begin
                // Owner reached FINISH, the bus is free from the next cycle
                busy <= 1'b0;
            end
        end
    end

    assign addr_phase = busy && addr_phase_v[owner];
    assign xfer       = xfer_v[owner];

    // At most one link is acknowledged or moving a transfer in any cycle
    ack_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(ack_q | addr_phase_v | data_phase_v)
    ) else $error("more than one master on the bus at once: ack %b addr %b data %b",
                  ack_q, addr_phase_v, data_phase_v);

    ack_on_free_bus: assert property (
        @(posedge clk) disable iff (!arst_n)
        (|ack_q) |-> $past(!(|(addr_phase_v | data_phase_v)))
    ) else $error("bus ack issued while the bus was owned");

endmodule

// File: src/mem_target.sv
`timescale 1ns/1ps

`include "bus_config.svh"

module mem_target
    import mem_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      addr_phase,
    input  bus_xfer_t xfer,
    output logic      wait_s,
    output mem_word_t rdata
);

    localparam int WS    = `BUS_WAIT_STATES;
    localparam int CNT_W = (WS > 0) ? $clog2(WS + 1) : 1;

    logic [CNT_W-1:0] cnt;
    logic             fire;
    bus_xfer_t        xfer_q;
    mem_word_t        rdata_q;
    mem_word_t        mem [`BUS_MEM_DEPTH];

    // ====================
    // Wait states
    // ====================

    // The last wait state is the WAIT cycle in which the owner sees wait_s low,
    // so wait_s itself stays high one cycle less than the count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (addr_phase) begin
            cnt <= CNT_W'(WS);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign wait_s = (cnt > CNT_W'(1));
    assign fire   = (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (addr_phase) begin
            xfer_q <= xfer;
        end
    end

    // ====================
    // Storage
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem <= '{default: '0};
        end else if (fire && xfer_q.op == MEM_WRITE) begin
            mem[xfer_q.addr] <= xfer_q.wdata;
        end
    end

    // Read word lands as the owner enters DATA and stays until the next read
    always_ff @(posedge clk) begin
        if (fire && xfer_q.op == MEM_READ) begin
            rdata_q <= mem[xfer_q.addr];
        end
    end

    assign rdata = rdata_q;

    no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n) addr_phase |-> cnt == '0
    ) else $error("address phase while a transfer is still in its wait states");

endmodule

// File: src/mem_bus_top.sv
`timescale 1ns/1ps

`include "bus_config.svh"

module mem_bus_top
    import mem_pkg::*;
    import bus_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic [`BUS_N_MASTERS-1:0]                     memop,
    input  logic [`BUS_N_MASTERS-1:0]                     op,
    input  logic [`BUS_N_MASTERS-1:0][`BUS_ADDR_W-1:0]    addr,
    input  logic [`BUS_N_MASTERS-1:0][`BUS_DATA_W-1:0]    wdata,
    output logic [`BUS_N_MASTERS-1:0]                     stall,
    output logic [`BUS_N_MASTERS-1:0]                     done,
    output logic [`BUS_N_MASTERS-1:0][`BUS_DATA_W-1:0]    rdata
);

    logic      addr_phase;
    bus_xfer_t xfer;
    logic      wait_s;
    mem_word_t mem_rdata;

    master_link_if link [`BUS_N_MASTERS] ();

    // One sequencer per CPU port
    for (genvar i = 0; i < `BUS_N_MASTERS; i++) begin : g_cpu
        cpu_bus_master u_master (
            .clk    (clk),
            .arst_n (arst_n),
            .memop  (memop[i]),
            .op     (mem_op_t'(op[i])),
            .addr   (addr[i]),
            .wdata  (wdata[i]),
            .stall  (stall[i]),
            .done   (done[i]),
            .rdata  (rdata[i]),
            .link   (link[i])
        );
    end

    bus_arbiter u_arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .links      (link),
        .addr_phase (addr_phase),
        .xfer       (xfer),
        .wait_s     (wait_s),
        .rdata      (mem_rdata)
    );

    mem_target u_target (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr_phase (addr_phase),
        .xfer       (xfer),
        .wait_s     (wait_s),
        .rdata      (mem_rdata)
    );

endmodule

// File: bench/mem_bus_checker.sv
`timescale 1ns/1ps

`include "bus_config.svh"

module mem_bus_checker
    import mem_pkg::*;
#(
    parameter int NAME_W = 128
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic [`BUS_N_MASTERS-1:0]                  memop,
    input  logic [`BUS_N_MASTERS-1:0]                  op,
    input  logic [`BUS_N_MASTERS-1:0]                  stall,
    input  logic [`BUS_N_MASTERS-1:0]                  done,
    input  logic [`BUS_N_MASTERS-1:0][`BUS_DATA_W-1:0] rdata,
    input  logic [`BUS_N_MASTERS-1:0][`BUS_DATA_W-1:0] exp_rdata,
    input  logic [`BUS_N_MASTERS-1:0][NAME_W-1:0]      test_name,
    output int                                         checks,
    output int                                         errors
);

    localparam int N        = `BUS_N_MASTERS;
    localparam int SOLO_LAT = 3 + `BUS_WAIT_STATES;
    // Worst case is waiting behind every other CPU for a full transfer each
    localparam int MAX_LAT  = N * (3 + `BUS_WAIT_STATES + 2);

    logic [N-1:0]  in_xfer;
    logic [N-1:0]  solo;
    logic [N-1:0]  held_ok;
    mem_word_t     held [N];
    int            lat [N];
    int            last_owner;

    function automatic string name_text(input logic [NAME_W-1:0] v);
        string s;
        byte   c;
        s = "";
        for (int k = NAME_W / 8 - 1; k >= 0; k--) begin
            c = v[k*8 +: 8];
            if (c != 0) begin
                s = $sformatf("%s%c", s, c);
            end
        end
        return s;
    endfunction

    // ====================
    // Per CPU reference
    // ====================

    always @(posedge clk or negedge arst_n) begin : sample
        logic         exp_stall;
        logic         others_busy;
        logic [N-1:0] waiting;
        int           exp_owner;
        int           j;
        if (!arst_n) begin
            in_xfer    = '0;
            solo       = '0;
            held_ok    = '0;
            checks     = 0;
            errors     = 0;
            last_owner = N - 1;
            for (int i = 0; i < N; i++) begin
                lat[i] = 0;
            end
        end else begin
            others_busy = |in_xfer;
            waiting     = in_xfer;
            for (int i = 0; i < N; i++) begin
                checks++;
                exp_stall = in_xfer[i] || memop[i];
                if (stall[i] !== exp_stall) begin
                    errors++;
                    $display("ERROR %s cpu%0d stall expected %b actual %b",
                             name_text(test_name[i]), i, exp_stall, stall[i]);
                end
                if (in_xfer[i]) begin
                    lat[i]++;
                end
                if (done[i] && !in_xfer[i]) begin
                    errors++;
                    $display("cpu%0d raised done with no operation outstanding", i);
                end else if (done[i]) begin
                    checks++;
                    if (solo[i] && lat[i] != SOLO_LAT) begin
                        errors++;
                        $display("ERROR %s cpu%0d latency expected %0d actual %0d",
                                 name_text(test_name[i]), i, SOLO_LAT, lat[i]);
                    end else if (lat[i] > MAX_LAT) begin
                        errors++;
                        $display("ERROR %s cpu%0d latency expected at most %0d actual %0d",
                                 name_text(test_name[i]), i, MAX_LAT, lat[i]);
                    end
                    // The ops of a group start together, so every CPU still waiting
                    // was requesting when this owner got the bus
                    exp_owner = -1;
                    for (int k = 1; k <= N; k++) begin
                        j = (last_owner + k) % N;
                        if (exp_owner < 0 && waiting[j]) begin
                            exp_owner = j;
                        end
                    end
                    checks++;
                    if (exp_owner != i) begin
                        errors++;
                        $display("ERROR %s grant order expected cpu%0d actual cpu%0d",
                                 name_text(test_name[i]), exp_owner, i);
                    end
                    last_owner = i;
                end
                if (done[i] && in_xfer[i] && op[i] == MEM_READ) begin
                    checks++;
                    if (rdata[i] !== exp_rdata[i]) begin
                        errors++;
                        $display("ERROR %s cpu%0d rdata expected %h actual %h",
                                 name_text(test_name[i]), i, exp_rdata[i], rdata[i]);
                    end
                    held[i]    = rdata[i];
                    held_ok[i] = 1'b1;
                end else if (held_ok[i] && rdata[i] !== held[i]) begin
                    errors++;
                    $display("ERROR %s cpu%0d held rdata expected %h actual %h",
                             name_text(test_name[i]), i, held[i], rdata[i]);
                end
                if (done[i]) begin
                    in_xfer[i] = 1'b0;
                end else if (memop[i] && !in_xfer[i]) begin
                    in_xfer[i] = 1'b1;
                    lat[i]     = 0;
                    solo[i]    = !others_busy && ($countones(memop) == 1);
                end
            end
        end
    end

endmodule

// File: bench/mem_bus_tb.sv
`timescale 1ns/1ps

`include "bus_config.svh"

module mem_bus_tb
    import mem_pkg::*;
();

    localparam int    N            = `BUS_N_MASTERS;
    localparam int    AW           = $bits(mem_addr_t);
    localparam int    DW           = $bits(mem_word_t);
    localparam int    NAME_W       = 128;
    localparam int    MAX_OPS      = 64;
    localparam int    RESET_CYCLES = 5;
    localparam int    MAX_GAP      = 4;
    localparam int    XFER_CYCLES  = 3 + `BUS_WAIT_STATES + 2;
    localparam string TRACE_FILE   = "bench/mem_bus_trace.txt";

    logic                     clk;
    logic                     arst_n;
    logic [N-1:0]             memop;
    logic [N-1:0]             op;
    logic [N-1:0][AW-1:0]     addr;
    logic [N-1:0][DW-1:0]     wdata;
    logic [N-1:0]             stall;
    logic [N-1:0]             done;
    logic [N-1:0][DW-1:0]     rdata;
    logic [N-1:0][DW-1:0]     exp_rdata;
    logic [N-1:0][NAME_W-1:0] test_name;
    int                       checks;
    int                       check_errors;

    logic [NAME_W-1:0] t_name [MAX_OPS];
    int                t_group [MAX_OPS];
    int                t_cpu [MAX_OPS];
    logic              t_write [MAX_OPS];
    logic [AW-1:0]     t_addr [MAX_OPS];
    logic [DW-1:0]     t_wdata [MAX_OPS];
    logic [DW-1:0]     t_exp [MAX_OPS];
    int                n_ops;
    int                n_groups;
    int                bench_errors;
    int                cycle_cnt;
    int                cycle_limit;

    mem_bus_top u_mem_bus_top (
        .clk    (clk),
        .arst_n (arst_n),
        .memop  (memop),
        .op     (op),
        .addr   (addr),
        .wdata  (wdata),
        .stall  (stall),
        .done   (done),
        .rdata  (rdata)
    );

    mem_bus_checker #(.NAME_W(NAME_W)) u_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .memop     (memop),
        .op        (op),
        .stall     (stall),
        .done      (done),
        .rdata     (rdata),
        .exp_rdata (exp_rdata),
        .test_name (test_name),
        .checks    (checks),
        .errors    (check_errors)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ====================
    // Trace handling
    // ====================

    task automatic load_trace();
        int                fd;
        int                nf;
        int                grp;
        int                cpu;
        int                last_grp;
        string             line;
        logic [NAME_W-1:0] name;
        logic [15:0]       kind;
        logic [AW-1:0]     a;
        logic [DW-1:0]     wd;
        logic [DW-1:0]     ex;
        last_grp = -1;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            bench_errors++;
            $display("could not open the trace file %s", TRACE_FILE);
            return;
        end
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                name = '0;
                kind = '0;
                nf = $sscanf(line, "%s %d %d %s %h %h %h", name, grp, cpu, kind, a, wd, ex);
                if (nf != 7 || cpu < 0 || cpu >= N || !(kind == "rd" || kind == "wr")) begin
                    bench_errors++;
                    $display("trace line could not be parsed: %s", line);
                end else begin
                    t_name[n_ops]  = name;
                    t_group[n_ops] = grp;
                    t_cpu[n_ops]   = cpu;
                    t_write[n_ops] = (kind == "wr");
                    t_addr[n_ops]  = a;
                    t_wdata[n_ops] = wd;
                    t_exp[n_ops]   = ex;
                    if (grp != last_grp) begin
                        n_groups++;
                        last_grp = grp;
                    end
                    n_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Issues one group on a falling edge and waits until every CPU in it is done
    task automatic run_group(input int first, output int next);
        logic [N-1:0] pending;
        int           idx;
        int           c;
        int           gap;
        pending = '0;
        idx = first;
        @(negedge clk);
        while (idx < n_ops && t_group[idx] == t_group[first]) begin
            c = t_cpu[idx];
            if (pending[c]) begin
                bench_errors++;
                $display("trace group %0d uses cpu%0d twice, the second one was skipped",
                         t_group[first], c);
            end else begin
                pending[c]   = 1'b1;
                memop[c]     = 1'b1;
                op[c]        = t_write[idx] ? MEM_WRITE : MEM_READ;
                addr[c]      = t_addr[idx];
                wdata[c]     = t_wdata[idx];
                exp_rdata[c] = t_exp[idx];
                test_name[c] = t_name[idx];
            end
            idx++;
        end
        next = idx;
        while (pending != '0) begin
            @(negedge clk);
            for (int i = 0; i < N; i++) begin
                if (pending[i] && done[i]) begin
                    memop[i]   = 1'b0;
                    pending[i] = 1'b0;
                end
            end
        end
        gap = 1 + int'($urandom % MAX_GAP);
        repeat (gap) @(negedge clk);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int idx;
        void'($urandom(8059));
        arst_n       = 1'b0;
        memop        = '0;
        op           = '0;
        addr         = '0;
        wdata        = '0;
        exp_rdata    = '0;
        test_name    = '0;
        n_ops        = 0;
        n_groups     = 0;
        bench_errors = 0;
        load_trace();
        if (n_ops == 0) begin
            bench_errors++;
            $display("the trace held no operations to run");
        end
        cycle_limit = RESET_CYCLES + 2 + n_ops * N * XFER_CYCLES + n_groups * (MAX_GAP + 2) + 10;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        idx = 0;
        while (idx < n_ops) begin
            run_group(idx, idx);
        end
        repeat (3) @(negedge clk);
        $display("checks %0d, checker errors %0d, bench errors %0d",
                 checks, check_errors, bench_errors);
        if (check_errors == 0 && bench_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial cycle_cnt = 0;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

// File: bench/mem_bus_trace.txt
# Columns: test name, group, cpu, op (rd or wr), address, write data, expected read data
# The last three columns are hex. Operations sharing a group number are issued together
rst_rd_solo      1 0 rd 5 0000 0000
rst_rd_all       2 0 rd 0 0000 0000
rst_rd_all       2 1 rd 7 0000 0000
rst_rd_all       2 2 rd c 0000 0000
rst_rd_all       2 3 rd f 0000 0000
wr_solo          3 1 wr 2 beef 0000
rd_back_solo     4 3 rd 2 0000 beef
wr_all           5 0 wr 8 1111 0000
wr_all           5 1 wr 9 2222 0000
wr_all           5 2 wr a 3333 0000
wr_all           5 3 wr b 4444 0000
rd_all           6 0 rd b 0000 4444
rd_all           6 1 rd 8 0000 1111
rd_all           6 2 rd 9 0000 2222
rd_all           6 3 rd a 0000 3333
mixed_all        7 0 wr 4 a5a5 0000
mixed_all        7 1 rd 2 0000 beef
mixed_all        7 2 wr d 0f0f 0000
mixed_all        7 3 rd 9 0000 2222
rd_pair          8 2 rd 4 0000 a5a5
rd_pair          8 0 rd d 0000 0f0f
overwrite_solo   9 3 wr 2 1234 0000
rd_over_solo    10 0 rd 2 0000 1234

// File: sources.f
+incdir+src
src/mem_pkg.sv
src/bus_pkg.sv
src/master_link_if.sv
src/cpu_bus_master.sv
src/bus_arbiter.sv
src/mem_target.sv
src/mem_bus_top.sv
bench/mem_bus_checker.sv
bench/mem_bus_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the bus testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module mem_bus_tb -o mem_bus_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/mem_bus_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
